/* source/inert_consts.svh */
`ifndef INERT_CONSTS_SVH
`define INERT_CONSTS_SVH

// One SPI frame is opcode byte plus data byte
`define SPI_WIDTH 16

// Clocks to wait after reset release before the sensor accepts commands
`define SETTLE_CYCLES 64

// Gyro config byte written once after settling
`define GYRO_CFG 8'h50

// Heading accumulator
`define ACC_WIDTH 32
`define HEADING_SHIFT 8

`endif

/* source/sensor_pkg.sv */
package sensor_pkg;

    // Bit 7 of the opcode selects a register read
    localparam int read_flag = 7;

    // Register access opcodes understood by the gyro
    typedef enum logic [7:0] {
        OP_WR_GYRO_CFG = 8'h11,  // Write gyro config register
        OP_RD_YAWL     = 8'hA6,  // Yaw rate low byte
        OP_RD_YAWH     = 8'hA7   // Yaw rate high byte
    } sensor_op_e;

    // Layout of one command frame, MSB first on the wire
    // Reads carry a zero data byte and the register value returns in the low byte
    typedef struct packed {
        sensor_op_e op;
        logic [7:0] data;
    } spi_cmd_t;

endpackage

/* source/ctrl_pkg.sv */
package ctrl_pkg;

    // Command sequencer in sensor_ctrl
    typedef enum logic [2:0] {
        SETTLE,
        CFG,
        CFG_WAIT,
        IDLE,
        RD_LO,
        RD_LO_WAIT,
        RD_HI,
        RD_HI_WAIT
    } ctrl_state_e;

    // SPI frame sequencer in spi_mnrch
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_FRONT,
        SPI_WORK,
        SPI_BACK
    } spi_state_e;

endpackage

/* source/spi_if.sv */
`timescale 1ns/1ps
`include "inert_consts.svh"

interface spi_if;

    logic                  wrt;      // One-cycle start strobe
    logic [`SPI_WIDTH-1:0] wt_data;  // Command word, valid with wrt
    logic                  done;     // High between frames
    logic [`SPI_WIDTH-1:0] rd_data;  // Word shifted in from the sensor

    // Controller side issues commands
    modport ctrl (
        output wrt,
        output wt_data,
        input  done,
        input  rd_data
    );

    // Master side runs the frame
    modport spi (
        input  wrt,
        input  wt_data,
        output done,
        output rd_data
    );

endinterface

/* source/spi_mnrch.sv */
`timescale 1ns/1ps
`include "inert_consts.svh"

module spi_mnrch (
    input  logic clk,
    input  logic rst_n,
    spi_if.spi   bus,
    input  logic MISO,
    output logic SS_n,
    output logic SCLK,
    output logic MOSI
);

    localparam int CNT_W = $clog2(`SPI_WIDTH);

    ctrl_pkg::spi_state_e state;
    ctrl_pkg::spi_state_e nxt_state;

    logic [3:0]            sclk_div;
    logic [CNT_W-1:0]      bit_cnt;
    logic [`SPI_WIDTH-1:0] shft_reg;
    logic                  miso_smpl;

    logic ld_sclk;   // Hold divider at preload
    logic init;      // Start of frame
    logic shft;      // Shift one bit
    logic set_done;  // End of frame
    logic smpl;
    logic shft_imm;
    logic last_bit;

    // SCLK is clk/16, preload gives a short high phase before the first fall
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            sclk_div <= 4'b1011;
        else if (ld_sclk)
            sclk_div <= 4'b1011;
        else
            sclk_div <= sclk_div + 4'd1;
    end

    assign SCLK     = sclk_div[3];
    assign smpl     = (sclk_div == 4'b0111);  // Rising SCLK next edge
    assign shft_imm = (sclk_div == 4'b1111);  // Falling SCLK next edge

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (init)
            bit_cnt <= '0;
        else if (shft)
            bit_cnt <= bit_cnt + 1'b1;
    end

    assign last_bit = (bit_cnt == CNT_W'(`SPI_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (smpl)
            miso_smpl <= MISO;
    end

    // Command goes out MSB first while the reply fills in from the bottom
    always_ff @(posedge clk) begin
        if (init)
            shft_reg <= bus.wt_data;
        else if (shft)
            shft_reg <= {shft_reg[`SPI_WIDTH-2:0], miso_smpl};
    end

    assign MOSI        = shft_reg[`SPI_WIDTH-1];
    assign bus.rd_data = shft_reg;

    always_comb begin
        nxt_state = state;
        ld_sclk   = 1'b0;
        init      = 1'b0;
        shft      = 1'b0;
        set_done  = 1'b0;
        case (state)
            ctrl_pkg::SPI_IDLE: begin
                if (bus.wrt) begin
                    init      = 1'b1;
                    nxt_state = ctrl_pkg::SPI_FRONT;
                end else begin
                    ld_sclk = 1'b1;
                end
            end
            ctrl_pkg::SPI_FRONT: begin
                // First falling edge only launches bit 15, nothing to shift yet
                if (shft_imm)
                    nxt_state = ctrl_pkg::SPI_WORK;
            end
            ctrl_pkg::SPI_WORK: begin
                if (shft_imm)
                    shft = 1'b1;
                if (last_bit)
                    nxt_state = ctrl_pkg::SPI_BACK;
            end
            ctrl_pkg::SPI_BACK: begin
                if (shft_imm) begin
                    shft      = 1'b1;  // Final bit
                    ld_sclk   = 1'b1;
                    set_done  = 1'b1;
                    nxt_state = ctrl_pkg::SPI_IDLE;
                end
            end
            default: nxt_state = ctrl_pkg::SPI_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= ctrl_pkg::SPI_IDLE;
        else
            state <= nxt_state;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            bus.done <= 1'b0;
        else if (set_done)
            bus.done <= 1'b1;
        else if (init)
            bus.done <= 1'b0;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            SS_n <= 1'b1;
        else if (set_done)
            SS_n <= 1'b1;
        else if (init)
            SS_n <= 1'b0;
    end

endmodule

/* source/sensor_ctrl.sv */
`timescale 1ns/1ps
`include "inert_consts.svh"

module sensor_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               INT,
    spi_if.ctrl                bus,
    output logic               rate_vld,
    output logic signed [15:0] rate
);

    localparam int SETTLE_W = $clog2(`SETTLE_CYCLES + 1);

    ctrl_pkg::ctrl_state_e state;
    ctrl_pkg::ctrl_state_e nxt_state;

    logic                int_meta;
    logic                int_sync;
    logic [SETTLE_W-1:0] settle_cnt;
    logic [7:0]          lo_byte;

    sensor_pkg::sensor_op_e cmd_op;
    sensor_pkg::spi_cmd_t   cmd;

    // INT comes straight from the sensor pin
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b0;
            int_sync <= 1'b0;
        end else begin
            int_meta <= INT;
            int_sync <= int_meta;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            settle_cnt <= '0;
        else if (state == ctrl_pkg::SETTLE)
            settle_cnt <= settle_cnt + 1'b1;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            ctrl_pkg::SETTLE:
                if (settle_cnt == SETTLE_W'(`SETTLE_CYCLES - 1))
                    nxt_state = ctrl_pkg::CFG;
            ctrl_pkg::CFG:        nxt_state = ctrl_pkg::CFG_WAIT;
            ctrl_pkg::CFG_WAIT:   if (bus.done) nxt_state = ctrl_pkg::IDLE;
            ctrl_pkg::IDLE:       if (int_sync) nxt_state = ctrl_pkg::RD_LO;
            ctrl_pkg::RD_LO:      nxt_state = ctrl_pkg::RD_LO_WAIT;
            ctrl_pkg::RD_LO_WAIT: if (bus.done) nxt_state = ctrl_pkg::RD_HI;
            ctrl_pkg::RD_HI:      nxt_state = ctrl_pkg::RD_HI_WAIT;
            ctrl_pkg::RD_HI_WAIT: if (bus.done) nxt_state = ctrl_pkg::IDLE;
            default:              nxt_state = ctrl_pkg::SETTLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= ctrl_pkg::SETTLE;
        else
            state <= nxt_state;
    end

    // Opcode follows the state, only the config write carries data
    always_comb begin
        case (state)
            ctrl_pkg::RD_LO: cmd_op = sensor_pkg::OP_RD_YAWL;
            ctrl_pkg::RD_HI: cmd_op = sensor_pkg::OP_RD_YAWH;
            default:         cmd_op = sensor_pkg::OP_WR_GYRO_CFG;
        endcase
        cmd.op   = cmd_op;
        cmd.data = cmd_op[sensor_pkg::read_flag] ? 8'h00 : `GYRO_CFG;
    end

    assign bus.wt_data = cmd;
    assign bus.wrt     = (state == ctrl_pkg::CFG) ||
                         (state == ctrl_pkg::RD_LO) ||
                         (state == ctrl_pkg::RD_HI);

    always_ff @(posedge clk) begin
        if (state == ctrl_pkg::RD_LO_WAIT && bus.done)
            lo_byte <= bus.rd_data[7:0];
    end

    // High byte is still on rd_data when the second frame ends
    always_ff @(posedge clk) begin
        if (state == ctrl_pkg::RD_HI_WAIT && bus.done)
            rate <= {bus.rd_data[7:0], lo_byte};
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            rate_vld <= 1'b0;
        else
            rate_vld <= (state == ctrl_pkg::RD_HI_WAIT) && bus.done;
    end

endmodule

/* source/yaw_integrator.sv */
`timescale 1ns/1ps
`include "inert_consts.svh"

module yaw_integrator (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rate_vld,
    input  logic signed [15:0] rate,
    output logic signed [15:0] heading
);

    localparam int RATE_W = 16;

    logic signed [`ACC_WIDTH-1:0] acc;
    logic signed [`ACC_WIDTH-1:0] rate_ext;
    logic signed [`ACC_WIDTH-1:0] acc_scaled;

    assign rate_ext = {{(`ACC_WIDTH - RATE_W){rate[RATE_W-1]}}, rate};

    // Running sum, wraps at the accumulator width
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            acc <= '0;
        else if (rate_vld)
            acc <= acc + rate_ext;
    end

    assign acc_scaled = acc >>> `HEADING_SHIFT;  // Arithmetic, keeps sign
    assign heading    = acc_scaled[RATE_W-1:0];

endmodule

/* source/inert_top.sv */
`timescale 1ns/1ps

module inert_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               MISO,
    input  logic               INT,      // Data ready from the gyro
    output logic               SS_n,
    output logic               SCLK,
    output logic               MOSI,
    output logic signed [15:0] yaw_rate,
    output logic               yaw_vld,
    output logic signed [15:0] heading
);

    // Command path between sequencer and SPI master
    spi_if spi_bus ();

    spi_mnrch spi_mnrch_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (spi_bus.spi),
        .MISO  (MISO),
        .SS_n  (SS_n),
        .SCLK  (SCLK),
        .MOSI  (MOSI)
    );

    sensor_ctrl sensor_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .INT      (INT),
        .bus      (spi_bus.ctrl),
        .rate_vld (yaw_vld),
        .rate     (yaw_rate)
    );

    // Rate strobe and sample go out and into the integrator unchanged
    yaw_integrator yaw_integrator_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rate_vld (yaw_vld),
        .rate     (yaw_rate),
        .heading  (heading)
    );

endmodule

/* test/inert_sva.sv */
`timescale 1ns/1ps
`include "inert_consts.svh"

module inert_sva (
    input logic clk,
    input logic rst_n,
    input logic SS_n,
    input logic SCLK,
    input logic yaw_vld
);

    // Outputs sit idle while reset is held
    reset_idle: assert property (@(posedge clk) !rst_n |-> (SS_n && !yaw_vld))
        else $error("SS_n or yaw_vld active during reset");

    // No clocking of the bus between frames
    sclk_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        SS_n |-> SCLK)
        else $error("SCLK low while SS_n deasserted");

    // Rate strobe lasts one clock
    vld_single: assert property (@(posedge clk) disable iff (!rst_n)
        yaw_vld |=> !yaw_vld)
        else $error("yaw_vld held for more than one cycle");

endmodule

bind inert_top inert_sva inert_sva_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .SS_n    (SS_n),
    .SCLK    (SCLK),
    .yaw_vld (yaw_vld)
);

/* test/inert_tb.sv */
`timescale 1ns/1ps
`include "inert_consts.svh"

module inert_tb;

    localparam int NUM_SAMPLES = 20;
    localparam int MAX_GAP     = 200;
    localparam int TIMEOUT_CYCLES = `SETTLE_CYCLES + NUM_SAMPLES * (2 * 300 + MAX_GAP) + 2000;

    logic clk = 1'b0;
    logic rst_n;
    logic MISO = 1'b0;
    logic INT;
    logic SS_n;
    logic SCLK;
    logic MOSI;
    logic signed [15:0] yaw_rate;
    logic               yaw_vld;
    logic signed [15:0] heading;

    logic signed [15:0] samples [NUM_SAMPLES];
    logic signed [15:0] cur_sample = 16'sd0;

    int cyc         = 0;
    int start_cycle = -1;
    int vld_cnt     = 0;
    int cmd_cnt     = 0;
    int yawh_cnt    = 0;
    int rx_bits     = 0;
    int tx_bits     = 0;
    int gap;
    logic [15:0] rx_word = 16'h0000;
    logic [7:0]  rx_op   = 8'h00;
    logic [7:0]  resp_byte;

    inert_top inert_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .MISO     (MISO),
        .INT      (INT),
        .SS_n     (SS_n),
        .SCLK     (SCLK),
        .MOSI     (MOSI),
        .yaw_rate (yaw_rate),
        .yaw_vld  (yaw_vld),
        .heading  (heading)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n)
            cyc <= cyc + 1;  // Cycles since reset release
    end

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Expected heading from the running sum of the first n samples
    function automatic logic signed [15:0] ref_heading(input int n);
        logic signed [31:0] sum;
        logic signed [31:0] scaled;
        sum = 32'sd0;
        for (int j = 0; j < n; j++)
            sum = sum + 32'(samples[j]);
        scaled = sum >>> `HEADING_SHIFT;
        return scaled[15:0];
    endfunction

    function automatic logic [15:0] expected_cmd(input int k);
        if (k == 0)
            return {8'(sensor_pkg::OP_WR_GYRO_CFG), `GYRO_CFG};
        else if ((k % 2) == 1)
            return {8'(sensor_pkg::OP_RD_YAWL), 8'h00};
        else
            return {8'(sensor_pkg::OP_RD_YAWH), 8'h00};
    endfunction

    // Sensor side receive, frame ends when SS_n rises
    always @(posedge SCLK or posedge SS_n) begin
        if (SS_n) begin
            if (rx_bits != 0) begin
                check_equal("rx_bits", 32'(rx_bits), 32'd16);
                check_equal("command", 32'(rx_word), 32'(expected_cmd(cmd_cnt)));
                if (cmd_cnt == 0)
                    check_equal("cfg_too_early", 32'(start_cycle >= `SETTLE_CYCLES), 32'd1);
                cmd_cnt = cmd_cnt + 1;
            end
            rx_bits = 0;
        end else begin
            rx_word = {rx_word[14:0], MOSI};
            rx_bits = rx_bits + 1;
            if (rx_bits == 8) begin
                rx_op = rx_word[7:0];  // Opcode byte complete
                if (rx_op == 8'(sensor_pkg::OP_RD_YAWH))
                    yawh_cnt = yawh_cnt + 1;
            end
        end
    end

    // Reply word has a zero upper byte and the register in the lower byte
    always @(negedge SCLK or posedge SS_n) begin
        if (SS_n) begin
            tx_bits = 0;
            MISO <= #1 1'b0;
        end else begin
            if (rx_op == 8'(sensor_pkg::OP_RD_YAWL))
                resp_byte = cur_sample[7:0];
            else if (rx_op == 8'(sensor_pkg::OP_RD_YAWH))
                resp_byte = cur_sample[15:8];
            else
                resp_byte = 8'h00;
            if (tx_bits < 8)
                MISO <= #1 1'b0;
            else
                MISO <= #1 resp_byte[15 - tx_bits];
            tx_bits = tx_bits + 1;
        end
    end

    // Compare process, outputs are stable at the falling clock edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (!SS_n && start_cycle < 0)
                start_cycle = cyc;  // First frame start
            check_equal("heading", 32'(heading), 32'(ref_heading(vld_cnt)));
            if (cyc < `SETTLE_CYCLES) begin
                check_equal("SS_n", 32'(SS_n), 32'd1);
                check_equal("yaw_vld", 32'(yaw_vld), 32'd0);
            end
            if (yaw_vld) begin
                check_equal("yaw_rate", 32'(yaw_rate), 32'(samples[vld_cnt]));
                vld_cnt = vld_cnt + 1;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: yaw_vld stopped arriving after %0d samples", vld_cnt);
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_n = 1'b1;
        INT   = 1'b0;
        void'($urandom(32'hff63_afb4));
        for (int i = 0; i < NUM_SAMPLES; i++)
            samples[i] = 16'($urandom);
        #1 rst_n = 1'b0;  // Reset edge ahead of the first clock
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        wait (cmd_cnt >= 1);  // Config write done

        for (int i = 0; i < NUM_SAMPLES; i++) begin
            gap = int'($urandom_range(MAX_GAP, 5));
            repeat (gap) @(posedge clk);
            #1;
            cur_sample = samples[i];
            INT = 1'b1;
            wait (yawh_cnt == i + 1);  // Drop before the controller is back in IDLE
            @(posedge clk);
            #1 INT = 1'b0;
            wait (vld_cnt == i + 1);
        end

        repeat (50) @(posedge clk);  // Catch stray pulses or frames
        check_equal("yaw_vld_count", 32'(vld_cnt), 32'(NUM_SAMPLES));
        check_equal("command_count", 32'(cmd_cnt), 32'(2 * NUM_SAMPLES + 1));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/sensor_pkg.sv
source/ctrl_pkg.sv
source/spi_if.sv
source/spi_mnrch.sv
source/sensor_ctrl.sv
source/yaw_integrator.sv
source/inert_top.sv
test/inert_sva.sv
test/inert_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the yaw-rate front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module inert_tb \
    -o inert_sim

out=$(./obj_dir/inert_sim 2>&1) || {
    echo "$out"
    exit 1
}
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
